//--- src/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

////////////////////
// Datapath widths
////////////////////

`define CPU_DATA_WIDTH      32
`define CPU_REG_ADDR_WIDTH  5
`define CPU_SHAMT_WIDTH     5

// General register file size
`define CPU_REG_COUNT       32

////////////////////
// Fetch
////////////////////

`define CPU_PC_STEP         4
`define CPU_RESET_PC        0

`endif

//--- src/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_WIDTH-1:0]     word_t;
    typedef logic [`CPU_REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`CPU_SHAMT_WIDTH-1:0]    shamt_t;

    // Major opcode in instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // R-type function in instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    // Execute stage operation
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU,
        ALU_LUI, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

endpackage

//--- src/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  cpu_pkg::word_t     instr,
    output cpu_pkg::reg_addr_t rs_addr,
    output cpu_pkg::reg_addr_t rt_addr,
    output cpu_pkg::reg_addr_t rd_addr,
    output cpu_pkg::alu_op_e   alu_op,
    output cpu_pkg::word_t     imm_ext,
    output logic               use_imm,
    output cpu_pkg::shamt_t    shamt,
    output logic               shamt_from_reg,
    output logic               is_shift,
    output logic               reg_w
);

    import cpu_pkg::*;

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t dest;
    logic      zero_ext;
    logic      known;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);

    ////////////////////
    // Field split
    ////////////////////

    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];
    assign shamt   = instr[10:6];

    // R-type writes rd, I-type writes rt
    assign dest    = (opcode == OP_SPECIAL) ? instr[15:11] : instr[20:16];
    assign rd_addr = dest;
    assign use_imm = (opcode != OP_SPECIAL);

    assign imm_ext = zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    // No write for $0 or anything not recognised
    assign reg_w = known && (dest != '0);

    ////////////////////
    // Operation map
    ////////////////////

    always_comb begin
        alu_op         = ALU_ADD;
        shamt_from_reg = 1'b0;
        is_shift       = 1'b0;
        zero_ext       = 1'b0;
        known          = 1'b1;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    FN_SLLV: alu_op = ALU_SLL;
                    FN_SRLV: alu_op = ALU_SRL;
                    FN_SRAV: alu_op = ALU_SRA;
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    default: known  = 1'b0;
                endcase
                is_shift       = (instr[5:3] == 3'b000);
                shamt_from_reg = (instr[5:2] == 4'b0001);
            end
            OP_ADDIU: alu_op = ALU_ADD;
            OP_SLTI:  alu_op = ALU_SLT;
            // Sign-extended, then compared unsigned
            OP_SLTIU: alu_op = ALU_SLTU;
            OP_ANDI: begin
                alu_op   = ALU_AND;
                zero_ext = 1'b1;
            end
            OP_ORI: begin
                alu_op   = ALU_OR;
                zero_ext = 1'b1;
            end
            OP_XORI: begin
                alu_op   = ALU_XOR;
                zero_ext = 1'b1;
            end
            OP_LUI:   alu_op = ALU_LUI;
            default:  known  = 1'b0;
        endcase
    end

endmodule

//--- src/fetch_decode.sv
`timescale 1ns/1ps

`include "cpu_settings.svh"

module fetch_decode (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::word_t     instr,
    output cpu_pkg::word_t     pc,
    output cpu_pkg::reg_addr_t rs_addr,
    output cpu_pkg::reg_addr_t rt_addr,
    output cpu_pkg::reg_addr_t rd_addr,
    output cpu_pkg::alu_op_e   alu_op,
    output cpu_pkg::word_t     imm_ext,
    output logic               use_imm,
    output logic               shamt_from_reg,
    output logic               is_shift,
    output logic               reg_w,
    output cpu_pkg::shamt_t    shamt
);

    import cpu_pkg::*;

    // Fetch/decode instruction register
    word_t fd_instr;

    ////////////////////
    // PC and IF/ID
    ////////////////////

    // All-zero word is sll $0, which decodes with reg_w low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= word_t'(`CPU_RESET_PC);
            fd_instr <= '0;
        end else begin
            pc       <= pc + word_t'(`CPU_PC_STEP);
            fd_instr <= instr;
        end
    end

    instr_decoder instr_decoder_i (
        .instr          ( fd_instr       ),
        .rs_addr        ( rs_addr        ),
        .rt_addr        ( rt_addr        ),
        .rd_addr        ( rd_addr        ),
        .alu_op         ( alu_op         ),
        .imm_ext        ( imm_ext        ),
        .use_imm        ( use_imm        ),
        .shamt          ( shamt          ),
        .shamt_from_reg ( shamt_from_reg ),
        .is_shift       ( is_shift       ),
        .reg_w          ( reg_w          )
    );

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

`include "cpu_settings.svh"

module reg_file (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    input  logic               wb_en,
    input  cpu_pkg::reg_addr_t wb_rd_addr,
    input  cpu_pkg::word_t     wb_data,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data
);

    import cpu_pkg::*;

    word_t regs [`CPU_REG_COUNT];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_rd_addr != '0)) begin
            regs[wb_rd_addr] <= wb_data;
        end
    end

    // $0 is hardwired and a same-cycle write passes straight through
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wb_en && (addr == wb_rd_addr)) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

endmodule

//--- src/alu_shifter.sv
`timescale 1ns/1ps

module alu_shifter (
    input  cpu_pkg::word_t   op_a,
    input  cpu_pkg::word_t   op_b,
    input  cpu_pkg::alu_op_e alu_op,
    input  cpu_pkg::shamt_t  shamt,
    output cpu_pkg::word_t   result
);

    import cpu_pkg::*;

    word_t alu_out;
    word_t shift_out;

    ////////////////////
    // ALU
    ////////////////////

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_out = op_a + op_b;
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_AND:  alu_out = op_a & op_b;
            ALU_OR:   alu_out = op_a | op_b;
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_NOR:  alu_out = ~(op_a | op_b);
            ALU_SLT:  alu_out = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_out = word_t'(op_a < op_b);
            ALU_LUI:  alu_out = {op_b[15:0], 16'h0000};
            default:  alu_out = '0;
        endcase
    end

    ////////////////////
    // Barrel shifter
    ////////////////////

    // Shifts always act on op_b (rt)
    always_comb begin
        case (alu_op)
            ALU_SLL: shift_out = op_b << shamt;
            ALU_SRL: shift_out = op_b >> shamt;
            ALU_SRA: shift_out = word_t'($signed(op_b) >>> shamt);
            default: shift_out = '0;
        endcase
    end

    // Result select
    always_comb begin
        case (alu_op)
            ALU_SLL, ALU_SRL, ALU_SRA: result = shift_out;
            default:                   result = alu_out;
        endcase
    end

endmodule

//--- src/exec_pipe.sv
`timescale 1ns/1ps

module exec_pipe (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    input  cpu_pkg::reg_addr_t rd_addr,
    input  cpu_pkg::alu_op_e   alu_op,
    input  cpu_pkg::word_t     imm_ext,
    input  logic               use_imm,
    input  cpu_pkg::shamt_t    shamt,
    input  logic               shamt_from_reg,
    input  logic               is_shift,
    input  logic               reg_w,
    input  cpu_pkg::word_t     rs_data,
    input  cpu_pkg::word_t     rt_data,
    output logic               wb_en,
    output cpu_pkg::reg_addr_t wb_rd_addr,
    output cpu_pkg::word_t     wb_data
);

    import cpu_pkg::*;

    // ID/EX control
    reg_addr_t ex_rs_addr;
    reg_addr_t ex_rt_addr;
    reg_addr_t ex_rd_addr;
    alu_op_e   ex_alu_op;
    logic      ex_use_imm;
    logic      ex_shamt_from_reg;
    logic      ex_is_shift;
    logic      ex_reg_w;

    // ID/EX payload
    word_t     ex_rs_data;
    word_t     ex_rt_data;
    word_t     ex_imm_ext;
    shamt_t    ex_shamt;

    word_t     fwd_a;
    word_t     fwd_b;
    word_t     op_b;
    shamt_t    shift_amt;
    word_t     ex_result;

    ////////////////////
    // ID/EX register
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_rs_addr        <= '0;
            ex_rt_addr        <= '0;
            ex_rd_addr        <= '0;
            ex_alu_op         <= ALU_ADD;
            ex_use_imm        <= 1'b0;
            ex_shamt_from_reg <= 1'b0;
            ex_is_shift       <= 1'b0;
            ex_reg_w          <= 1'b0;
        end else begin
            ex_rs_addr        <= rs_addr;
            ex_rt_addr        <= rt_addr;
            ex_rd_addr        <= rd_addr;
            ex_alu_op         <= alu_op;
            ex_use_imm        <= use_imm;
            ex_shamt_from_reg <= shamt_from_reg;
            ex_is_shift       <= is_shift;
            ex_reg_w          <= reg_w;
        end
    end

    always_ff @(posedge clk) begin
        ex_rs_data <= rs_data;
        ex_rt_data <= rt_data;
        ex_imm_ext <= imm_ext;
        ex_shamt   <= shamt;
    end

    ////////////////////
    // Execute
    ////////////////////

    // Only source of forwarding is the EX/WB register
    assign fwd_a = (wb_en && (wb_rd_addr != '0) && (wb_rd_addr == ex_rs_addr)) ?
                   wb_data : ex_rs_data;
    assign fwd_b = (wb_en && (wb_rd_addr != '0) && (wb_rd_addr == ex_rt_addr)) ?
                   wb_data : ex_rt_data;

    assign op_b = ex_use_imm ? ex_imm_ext : fwd_b;

    // Variable shifts take rs[4:0] and non-shift ops get a zero amount
    assign shift_amt = !ex_is_shift      ? '0 :
                       ex_shamt_from_reg ? shamt_t'(fwd_a) : ex_shamt;

    alu_shifter alu_shifter_i (
        .op_a   ( fwd_a     ),
        .op_b   ( op_b      ),
        .alu_op ( ex_alu_op ),
        .shamt  ( shift_amt ),
        .result ( ex_result )
    );

    ////////////////////
    // EX/WB register
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_en      <= 1'b0;
            wb_rd_addr <= '0;
        end else begin
            wb_en      <= ex_reg_w;
            wb_rd_addr <= ex_rd_addr;
        end
    end

    always_ff @(posedge clk) begin
        wb_data <= ex_result;
    end

endmodule

//--- src/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::word_t     instr,
    output cpu_pkg::word_t     pc,
    output logic               wb_en,
    output cpu_pkg::reg_addr_t wb_rd_addr,
    output cpu_pkg::word_t     wb_data
);

    import cpu_pkg::*;

    // Decode stage outputs
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    reg_addr_t rd_addr;
    alu_op_e   alu_op;
    word_t     imm_ext;
    logic      use_imm;
    logic      shamt_from_reg;
    logic      is_shift;
    logic      reg_w;
    shamt_t    shamt;

    // Register read data
    word_t     rs_data;
    word_t     rt_data;

    fetch_decode fetch_decode_i (
        .clk            ( clk            ),
        .arst_n         ( arst_n         ),
        .instr          ( instr          ),
        .pc             ( pc             ),
        .rs_addr        ( rs_addr        ),
        .rt_addr        ( rt_addr        ),
        .rd_addr        ( rd_addr        ),
        .alu_op         ( alu_op         ),
        .imm_ext        ( imm_ext        ),
        .use_imm        ( use_imm        ),
        .shamt_from_reg ( shamt_from_reg ),
        .is_shift       ( is_shift       ),
        .reg_w          ( reg_w          ),
        .shamt          ( shamt          )
    );

    reg_file reg_file_i (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .rs_addr    ( rs_addr    ),
        .rt_addr    ( rt_addr    ),
        .wb_en      ( wb_en      ),
        .wb_rd_addr ( wb_rd_addr ),
        .wb_data    ( wb_data    ),
        .rs_data    ( rs_data    ),
        .rt_data    ( rt_data    )
    );

    exec_pipe exec_pipe_i (
        .clk            ( clk            ),
        .arst_n         ( arst_n         ),
        .rs_addr        ( rs_addr        ),
        .rt_addr        ( rt_addr        ),
        .rd_addr        ( rd_addr        ),
        .alu_op         ( alu_op         ),
        .imm_ext        ( imm_ext        ),
        .use_imm        ( use_imm        ),
        .shamt          ( shamt          ),
        .shamt_from_reg ( shamt_from_reg ),
        .is_shift       ( is_shift       ),
        .reg_w          ( reg_w          ),
        .rs_data        ( rs_data        ),
        .rt_data        ( rt_data        ),
        .wb_en          ( wb_en          ),
        .wb_rd_addr     ( wb_rd_addr     ),
        .wb_data        ( wb_data        )
    );

endmodule

//--- tests/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::word_t     pc,
    input  logic               wb_en,
    input  cpu_pkg::reg_addr_t wb_rd_addr,
    input  cpu_pkg::word_t     wb_data,
    input  logic               check_en,
    input  cpu_pkg::word_t     exp_pc,
    input  logic               exp_en,
    input  cpu_pkg::reg_addr_t exp_rd,
    input  cpu_pkg::word_t     exp_data,
    input  logic [127:0]       exp_name,
    output int                 check_count,
    output int                 value_errors,
    output int                 enable_errors
);

    int n_checks = 0;
    int n_value_errors = 0;
    int n_enable_errors = 0;

    assign check_count   = n_checks;
    assign value_errors  = n_value_errors;
    assign enable_errors = n_enable_errors;

    ////////////////////
    // Writeback compare
    ////////////////////

    // Sees the EX/WB outputs of the cycle that just ended
    always @(posedge clk) begin
        if (arst_n && check_en) begin
            n_checks = n_checks + 1;
            // Fetch address steps by four from the reset PC
            if (pc !== exp_pc) begin
                n_value_errors = n_value_errors + 1;
                $display("CHECK FAILED pc sequence: expected 0x%08h, actual 0x%08h",
                         exp_pc, pc);
            end
            if (exp_en) begin
                if (wb_en !== 1'b1) begin
                    n_enable_errors = n_enable_errors + 1;
                    $display("Missing register write in %0s: r%0d was due but wb_en is low",
                             exp_name, exp_rd);
                end else begin
                    if (wb_rd_addr !== exp_rd) begin
                        n_value_errors = n_value_errors + 1;
                        $display("CHECK FAILED %0s destination: expected r%0d, actual r%0d",
                                 exp_name, exp_rd, wb_rd_addr);
                    end
                    if (wb_data !== exp_data) begin
                        n_value_errors = n_value_errors + 1;
                        $display("CHECK FAILED %0s data: expected 0x%08h, actual 0x%08h",
                                 exp_name, exp_data, wb_data);
                    end
                end
            end else if (wb_en !== 1'b0) begin
                n_enable_errors = n_enable_errors + 1;
                $display("Unexpected register write in %0s: r%0d got 0x%08h with no write due",
                         exp_name, wb_rd_addr, wb_data);
            end
        end
    end

endmodule

//--- tests/tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;

    import cpu_pkg::*;

    localparam int MAX_ENTRIES = 64;

    // Test names of up to 16 characters
    typedef logic [127:0] name_t;

    logic      clk;
    logic      arst_n;
    word_t     instr;
    word_t     pc;
    logic      wb_en;
    reg_addr_t wb_rd_addr;
    word_t     wb_data;

    logic      check_en;
    word_t     exp_pc;
    logic      exp_en;
    reg_addr_t exp_rd;
    word_t     exp_data;
    name_t     exp_name;
    int        check_count;
    int        value_errors;
    int        enable_errors;

    // Program table
    word_t     prog_word [MAX_ENTRIES];
    logic      prog_en   [MAX_ENTRIES];
    reg_addr_t prog_rd   [MAX_ENTRIES];
    word_t     prog_data [MAX_ENTRIES];
    name_t     prog_name [MAX_ENTRIES];
    int        prog_len = 0;
    logic      table_ready = 1'b0;

    // Architectural register state seen by the golden model
    word_t     model_regs [32];
    word_t     rng_state;

    cpu_core cpu_core_i (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .instr      ( instr      ),
        .pc         ( pc         ),
        .wb_en      ( wb_en      ),
        .wb_rd_addr ( wb_rd_addr ),
        .wb_data    ( wb_data    )
    );

    cpu_checker cpu_checker_i (
        .clk           ( clk           ),
        .arst_n        ( arst_n        ),
        .pc            ( pc            ),
        .wb_en         ( wb_en         ),
        .wb_rd_addr    ( wb_rd_addr    ),
        .wb_data       ( wb_data       ),
        .check_en      ( check_en      ),
        .exp_pc        ( exp_pc        ),
        .exp_en        ( exp_en        ),
        .exp_rd        ( exp_rd        ),
        .exp_data      ( exp_data      ),
        .exp_name      ( exp_name      ),
        .check_count   ( check_count   ),
        .value_errors  ( value_errors  ),
        .enable_errors ( enable_errors )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////
    // Encoders and model
    ////////////////////

    function automatic word_t r_op(input logic [5:0] fn, input reg_addr_t rd,
                                   input reg_addr_t rs, input reg_addr_t rt, input shamt_t sh);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t i_op(input logic [5:0] op, input reg_addr_t rt,
                                   input reg_addr_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t xorshift32(input word_t x);
        word_t s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Expected writeback of one instruction in program order
    function automatic void golden(input word_t word, output logic en,
                                   output reg_addr_t dest, output word_t value);
        logic [5:0] op;
        logic [5:0] fn;
        word_t      a;
        word_t      b;
        word_t      sext;
        word_t      zext;
        logic       known;
        op    = word[31:26];
        fn    = word[5:0];
        a     = model_regs[word[25:21]];
        b     = model_regs[word[20:16]];
        sext  = {{16{word[15]}}, word[15:0]};
        zext  = {16'h0000, word[15:0]};
        known = 1'b1;
        value = '0;
        dest  = (op == OP_SPECIAL) ? word[15:11] : word[20:16];
        case (op)
            OP_SPECIAL: begin
                case (fn)
                    FN_SLL:  value = b << word[10:6];
                    FN_SRL:  value = b >> word[10:6];
                    FN_SRA:  value = $signed(b) >>> word[10:6];
                    FN_SLLV: value = b << a[4:0];
                    FN_SRLV: value = b >> a[4:0];
                    FN_SRAV: value = $signed(b) >>> a[4:0];
                    FN_ADDU: value = a + b;
                    FN_SUBU: value = a - b;
                    FN_AND:  value = a & b;
                    FN_OR:   value = a | b;
                    FN_XOR:  value = a ^ b;
                    FN_NOR:  value = ~(a | b);
                    FN_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU: value = (a < b) ? 32'd1 : 32'd0;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: value = a + sext;
            OP_SLTI:  value = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            OP_SLTIU: value = (a < sext) ? 32'd1 : 32'd0;
            OP_ANDI:  value = a & zext;
            OP_ORI:   value = a | zext;
            OP_XORI:  value = a ^ zext;
            OP_LUI:   value = {word[15:0], 16'h0000};
            default:  known = 1'b0;
        endcase
        en = known && (dest != '0);
    endfunction

    task automatic add_instr(input word_t word, input name_t name);
        logic      en;
        reg_addr_t dest;
        word_t     value;
        golden(word, en, dest, value);
        prog_word[prog_len] = word;
        prog_en[prog_len]   = en;
        prog_rd[prog_len]   = dest;
        prog_data[prog_len] = value;
        prog_name[prog_len] = name;
        if (en) begin
            model_regs[dest] = value;
        end
        prog_len = prog_len + 1;
    endtask

    task automatic load_const(input reg_addr_t rd, input word_t value);
        add_instr(i_op(OP_LUI, rd, 0, value[31:16]), "lui const");
        add_instr(i_op(OP_ORI, rd, rd, value[15:0]), "ori const");
    endtask

    task automatic build_program();
        word_t k1;
        word_t k2;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        rng_state = 32'd58;
        rng_state = xorshift32(rng_state);
        k1 = rng_state;
        rng_state = xorshift32(rng_state);
        k2 = rng_state;
        // Immediate forms and random constants
        add_instr(i_op(OP_ADDIU, 1, 0, 16'hfff6), "addiu neg");
        add_instr(i_op(OP_ANDI, 2, 1, 16'h8f0f), "andi zext");
        add_instr(i_op(OP_ORI, 3, 0, 16'h8001), "ori zext");
        add_instr(i_op(OP_XORI, 4, 1, 16'hffff), "xori zext");
        add_instr(i_op(OP_SLTI, 5, 1, 16'h0000), "slti");
        add_instr(i_op(OP_SLTIU, 6, 1, 16'hffff), "sltiu");
        load_const(7, k1);
        load_const(8, k2);
        // Register-register ALU
        load_const(12, 32'h8000_0001);
        add_instr(r_op(FN_ADDU, 13, 12, 12, 0), "addu wrap");
        add_instr(r_op(FN_SUBU, 14, 7, 8, 0), "subu");
        add_instr(r_op(FN_AND, 15, 7, 8, 0), "and");
        add_instr(r_op(FN_OR, 16, 7, 8, 0), "or");
        add_instr(r_op(FN_XOR, 17, 7, 8, 0), "xor");
        add_instr(r_op(FN_NOR, 18, 7, 8, 0), "nor");
        add_instr(r_op(FN_SLT, 19, 1, 3, 0), "slt mixed sign");
        add_instr(r_op(FN_SLTU, 20, 1, 3, 0), "sltu mixed sign");
        // Shifts
        add_instr(r_op(FN_SLL, 21, 0, 7, 4), "sll");
        add_instr(r_op(FN_SRL, 22, 0, 1, 8), "srl");
        add_instr(r_op(FN_SRA, 23, 0, 1, 4), "sra");
        add_instr(r_op(FN_SRA, 24, 0, 12, 31), "sra sign fill");
        add_instr(i_op(OP_ADDIU, 25, 0, 16'h0023), "addiu shamt");
        add_instr(r_op(FN_SLLV, 26, 25, 7, 0), "sllv");
        add_instr(r_op(FN_SRLV, 27, 25, 1, 0), "srlv");
        add_instr(r_op(FN_SRAV, 28, 25, 12, 0), "srav");
        // Dependency distances 1, 2 and 3
        add_instr(i_op(OP_ADDIU, 29, 0, 16'd100), "fwd base");
        add_instr(r_op(FN_ADDU, 30, 29, 29, 0), "fwd exwb");
        add_instr(r_op(FN_SUBU, 31, 30, 29, 0), "fwd bypass");
        add_instr(r_op(FN_XOR, 2, 29, 30, 0), "fwd regfile");
        add_instr(r_op(FN_OR, 3, 30, 31, 0), "fwd mixed");
        // Register zero and unknown encodings
        add_instr(i_op(OP_ADDIU, 0, 1, 16'h0007), "write r0");
        add_instr(r_op(FN_ADDU, 4, 0, 0, 0), "read r0");
        add_instr(i_op(6'h3f, 5, 1, 16'h1234), "unknown opcode");
        add_instr(r_op(6'h3f, 5, 1, 7, 0), "unknown funct");
        add_instr('0, "nop");
        add_instr(r_op(FN_OR, 5, 0, 7, 0), "or r0");
        add_instr(i_op(OP_ADDIU, 6, 0, 16'h1234), "addiu r0");
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin : stimulus
        int idx;
        int slot;
        int pending [$];
        arst_n   = 1'b0;
        instr    = '0;
        check_en = 1'b0;
        exp_pc   = '0;
        exp_en   = 1'b0;
        exp_rd   = '0;
        exp_data = '0;
        exp_name = "idle";
        build_program();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        // Nothing retires in the first three cycles
        repeat (3) pending.push_back(-1);
        for (int cyc = 0; cyc < prog_len + 3; cyc++) begin
            idx = int'(pc >> 2);
            if (idx < prog_len) begin
                instr = prog_word[idx];
                pending.push_back(idx);
            end else begin
                instr = '0;
                pending.push_back(-1);
            end
            slot     = pending.pop_front();
            check_en = 1'b1;
            exp_pc   = word_t'(cyc * 4);
            if (slot < 0) begin
                exp_en   = 1'b0;
                exp_rd   = '0;
                exp_data = '0;
                exp_name = "reset latency";
            end else begin
                exp_en   = prog_en[slot];
                exp_rd   = prog_rd[slot];
                exp_data = prog_data[slot];
                exp_name = prog_name[slot];
            end
            @(posedge clk);
            #1;
        end
        check_en = 1'b0;
        $display("Checks run: %0d, value errors: %0d, write-enable errors: %0d",
                 check_count, value_errors, enable_errors);
        if (value_errors + enable_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_ready);
        #((prog_len + 10) * 8);
        $display("Watchdog expired: the run did not finish within %0d clock cycles",
                 prog_len + 10);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+src
src/cpu_pkg.sv
src/instr_decoder.sv
src/fetch_decode.sv
src/reg_file.sv
src/alu_shifter.sv
src/exec_pipe.sv
src/cpu_core.sv
tests/cpu_checker.sv
tests/tb_cpu_core.sv

//--- run.sh
#!/bin/sh
# Build and run the cpu_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_cpu_core -f filelist.f -o sim_tb_cpu_core

output=$(./obj_dir/sim_tb_cpu_core 2>&1)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
